/* Makefile */
TOP = tb_hdr

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir

/* bench/hdr_patterns.txt */
# w addr data | s cp toc mode cnt code | e preamble data | d ends with done | a n abort at word n
# all fields hex, the bench appends the two parity bits to each expected word
w 000 1234
w 001 beef
w 040 c0de
w 041 face
w 042 0f0f
w 043 8001
w 044 7ffe
w 045 5555
w 1c2 d00d
s 0 1 6 3 00
e 2 c0de
e 2 face
e 2 0f0f
d
s 1 1 6 2 a5
e 1 a500
e 2 1234
e 2 beef
d
s 0 0 6 3 00
e 2 c0de
e 2 face
e 2 0f0f
s 0 0 6 3 00
e 2 c0de
e 2 face
e 2 0f0f
s 1 1 6 1 3c
e 1 3c00
e 2 1234
d
s 1 0 6 2 5a
e 1 5a00
e 2 1234
e 2 beef
s 0 1 6 2 00
e 2 d00d
e 2 c0de
e 2 face
d
s 0 0 3 2 00
e 2 c0de
e 2 face
d
s 0 1 6 8 00
e 2 c0de
e 2 face
e 2 0f0f
e 2 8001
e 2 7ffe
e 2 5555
a 3

/* bench/tb_clk_gen.sv */
// testbench clock and reset
`timescale 1ns/10ps

module tb_clk_gen (
  output logic o_sys_clk,
  output logic o_sys_rst_n
);

  localparam int RST_CYCLES = 4;

  initial begin
    o_sys_clk = 1'b0;
    forever #2 o_sys_clk = ~o_sys_clk;  // 4 ns period
  end

  initial begin
    o_sys_rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge o_sys_clk);
    o_sys_rst_n <= 1'b1;
  end

endmodule

/* bench/tb_hdr.sv */
// hdr-ddr path testbench
`timescale 1ns/10ps
`include "hdr_cfg.svh"

module tb_hdr;

  import hdr_pkg::*;

  logic                   clk;
  logic                   rst_n;
  logic                   hdr_en;
  logic                   cp;
  logic                   toc;
  logic [`HDR_MODE_W-1:0] mode;
  logic [`HDR_CNT_W-1:0]  word_cnt;
  logic [`HDR_CODE_W-1:0] ccc_code;
  logic                   regf_wr_en;
  logic [`HDR_ADDR_W-1:0] regf_wr_addr;
  logic [`HDR_DATA_W-1:0] regf_wr_data;
  logic                   word_valid;
  hdr_word_t              dut_word;
  logic                   hdr_done;

  // contents of the patterns file
  logic [`HDR_ADDR_W-1:0] pre_addr[$];
  logic [`HDR_DATA_W-1:0] pre_data[$];
  logic                   fr_cp[$];
  logic                   fr_toc[$];
  logic [`HDR_MODE_W-1:0] fr_mode[$];
  logic [`HDR_CNT_W-1:0]  fr_cnt[$];
  logic [`HDR_CODE_W-1:0] fr_code[$];
  int                     fr_word0[$];  // index of the first word of each frame
  hdr_payload_t           exp_payload[$];
  int                     sq_frame0[$];
  int                     sq_word0[$];
  int                     sq_abort[$];  // 0 when the sequence ends with done

  int word_idx;
  int w_end;
  bit done_seen;
  bit running;
  int cycles;
  int limit;

  tb_clk_gen u_clk (.o_sys_clk(clk), .o_sys_rst_n(rst_n));

  hdr_top uut (
    .i_sys_clk      (clk),          .i_sys_rst_n    (rst_n),
    .i_hdr_en       (hdr_en),       .i_cp           (cp),
    .i_toc          (toc),          .i_mode         (mode),
    .i_word_cnt     (word_cnt),     .i_ccc_code     (ccc_code),
    .i_regf_wr_en   (regf_wr_en),   .i_regf_wr_addr (regf_wr_addr),
    .i_regf_wr_data (regf_wr_data), .o_word_valid   (word_valid),
    .o_word         (dut_word),     .o_hdr_done     (hdr_done)
  );

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1, "run stopped");
  endtask

  // p1 over odd bits and p0 over even bits inverted
  function automatic hdr_word_t add_parity(input hdr_payload_t p);
    logic p1;
    logic p0;
    p1 = 1'b0;
    p0 = 1'b1;
    for (int i = 0; i < `HDR_DATA_W; i++) begin
      if (i % 2 == 1) p1 ^= p.data[i];
      else            p0 ^= p.data[i];
    end
    return {p.preamble, p.data, p1, p0};
  endfunction

  task automatic check_word(input hdr_word_t got);
    hdr_word_t want;
    want = add_parity(exp_payload[word_idx]);
    if (got !== want)
      fail_run($sformatf("[FAIL] %0t word %0d: got %h, expected %h", $time, word_idx, got, want));
  endtask

  task automatic check_done();
    if (word_idx < w_end)
      fail_run($sformatf("[FAIL] %0t done pulse before word %0d of %0d", $time, word_idx, w_end));
    done_seen = 1'b1;
  endtask

  task automatic load_patterns();
    int    fd;
    string line;
    string tag;
    int    a, b, c, d, e;
    bit    new_seq;
    fd = $fopen("bench/hdr_patterns.txt", "r");
    if (fd == 0) fail_run("cannot open bench/hdr_patterns.txt");
    new_seq = 1'b1;
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line.substr(0, 0) == "#") continue;
      void'($sscanf(line, "%s %h %h %h %h %h", tag, a, b, c, d, e));
      case (tag)
        "w": begin
          pre_addr.push_back(a[`HDR_ADDR_W-1:0]);
          pre_data.push_back(b[`HDR_DATA_W-1:0]);
        end
        "s": begin
          if (new_seq) begin                 // first frame opens a sequence
            sq_frame0.push_back(fr_cp.size());
            sq_word0.push_back(exp_payload.size());
            sq_abort.push_back(0);
            new_seq = 1'b0;
          end
          fr_cp.push_back(a[0]);
          fr_toc.push_back(b[0]);
          fr_mode.push_back(c[`HDR_MODE_W-1:0]);
          fr_cnt.push_back(d[`HDR_CNT_W-1:0]);
          fr_code.push_back(e[`HDR_CODE_W-1:0]);
          fr_word0.push_back(exp_payload.size());
        end
        "e": exp_payload.push_back({a[1:0], b[`HDR_DATA_W-1:0]});
        "d": new_seq = 1'b1;
        "a": begin
          sq_abort[sq_abort.size()-1] = a;
          new_seq = 1'b1;
        end
        default: fail_run($sformatf("bad line in patterns file: %s", line));
      endcase
    end
    $fclose(fd);
  endtask

  task automatic apply_settings(input int f);
    cp       <= fr_cp[f];
    toc      <= fr_toc[f];
    mode     <= fr_mode[f];
    word_cnt <= fr_cnt[f];
    ccc_code <= fr_code[f];
  endtask

  task automatic run_sequence(input int s);
    int f;
    int f_end;
    int gap;
    f     = sq_frame0[s];
    f_end = (s + 1 < sq_frame0.size()) ? sq_frame0[s+1] : fr_cp.size();
    w_end = (s + 1 < sq_word0.size()) ? sq_word0[s+1] : exp_payload.size();
    word_idx  = sq_word0[s];
    done_seen = 1'b0;
    apply_settings(f);
    hdr_en <= 1'b1;
    while (word_idx < w_end || (sq_abort[s] == 0 && !done_seen)) begin
      @(posedge clk);
      if (word_valid) begin
        if (word_idx >= w_end) fail_run("word arrived after the last expected one");
        check_word(dut_word);
        if (f + 1 < f_end && word_idx == fr_word0[f]) begin  // next frame settings
          f++;
          apply_settings(f);
        end
        if (sq_abort[s] != 0 && word_idx - sq_word0[s] + 1 == sq_abort[s]) hdr_en <= 1'b0;
        word_idx++;
      end
      if (hdr_done) begin
        if (sq_abort[s] != 0) fail_run("done pulse in an aborted sequence");
        check_done();
        hdr_en <= 1'b0;
      end
    end
    gap = 10 + int'($urandom % 8);
    repeat (gap) begin                       // bus must stay quiet
      @(posedge clk);
      if (word_valid || hdr_done) fail_run("output activity after the end of a sequence");
    end
  endtask

  always @(posedge clk) begin
    if (running) begin
      cycles++;
      if (cycles > limit) fail_run($sformatf("timeout after %0d cycles", limit));
    end
  end

  initial begin
    void'($urandom(17));
    hdr_en       = 1'b0;
    cp           = 1'b0;
    toc          = 1'b0;
    mode         = `HDR_MODE_DDR;
    word_cnt     = '0;
    ccc_code     = '0;
    regf_wr_en   = 1'b0;
    regf_wr_addr = '0;
    regf_wr_data = '0;
    running      = 1'b0;
    cycles       = 0;
    load_patterns();
    limit = exp_payload.size() + 40 * sq_frame0.size();
    wait (rst_n);
    @(posedge clk);
    foreach (pre_addr[i]) begin              // preload through the host port
      regf_wr_en   <= 1'b1;
      regf_wr_addr <= pre_addr[i];
      regf_wr_data <= pre_data[i];
      @(posedge clk);
    end
    regf_wr_en <= 1'b0;
    running = 1'b1;
    foreach (sq_frame0[s]) run_sequence(s);
    $display("Everything OK");
    $finish;
  end

endmodule

/* src/ccc_frame_gen.sv */
// ccc frame generator
`timescale 1ns/10ps
`include "hdr_cfg.svh"

module ccc_frame_gen (
  input  logic                    i_sys_clk,
  input  logic                    i_sys_rst_n,
  input  logic                    i_en,
  input  logic                    i_dummy,
  input  logic [`HDR_CNT_W-1:0]   i_word_cnt,
  input  logic [`HDR_CODE_W-1:0]  i_ccc_code,
  input  logic [`HDR_DATA_W-1:0]  i_rd_data,
  output logic                    o_rd_en,
  output logic [`HDR_ADDR_W-1:0]  o_rd_addr,
  output logic                    o_valid,
  output hdr_pkg::hdr_payload_t   o_payload,
  output logic                    o_done
);

  logic                   en_d;
  logic                   start;
  logic                   busy;     // data reads still to issue
  logic [`HDR_CNT_W-1:0]  left;
  logic [`HDR_ADDR_W-1:0] ptr;
  logic                   iss_vld;
  logic                   iss_cmd;
  logic                   iss_last;
  logic                   ret_vld;  // lines up with read data
  logic                   ret_cmd;
  logic                   ret_last;

  assign start = i_en && !en_d;

  always_ff @(posedge i_sys_clk or negedge i_sys_rst_n) begin
    if (!i_sys_rst_n) begin
      en_d      <= 1'b0;
      busy      <= 1'b0;
      left      <= '0;
      ptr       <= `HDR_CCC_BASE;
      iss_vld   <= 1'b0;
      iss_cmd   <= 1'b0;
      iss_last  <= 1'b0;
      o_rd_en   <= 1'b0;
      o_rd_addr <= `HDR_IDLE_ADDR;
    end else begin
      en_d      <= i_en;
      iss_vld   <= 1'b0;
      iss_cmd   <= 1'b0;
      iss_last  <= 1'b0;
      o_rd_en   <= 1'b0;
      o_rd_addr <= `HDR_IDLE_ADDR;
      if (!i_en) begin
        busy <= 1'b0;
      end else if (start && i_dummy) begin   // single dummy word
        o_rd_en   <= 1'b1;
        o_rd_addr <= `HDR_DUMMY_ADDR;
        iss_vld   <= 1'b1;
        iss_last  <= 1'b1;
      end else if (start) begin              // command slot needs no read
        iss_vld  <= 1'b1;
        iss_cmd  <= 1'b1;
        iss_last <= (i_word_cnt == '0);
        busy     <= (i_word_cnt != '0);
        left     <= i_word_cnt;
        ptr      <= `HDR_CCC_BASE;
      end else if (busy) begin
        o_rd_en   <= 1'b1;
        o_rd_addr <= ptr;
        iss_vld   <= 1'b1;
        iss_last  <= (left == 1);
        ptr       <= ptr + 1'b1;
        left      <= left - 1'b1;
        busy      <= (left != 1);
      end
    end
  end

  always_ff @(posedge i_sys_clk or negedge i_sys_rst_n) begin
    if (!i_sys_rst_n) begin
      ret_vld  <= 1'b0;
      ret_cmd  <= 1'b0;
      ret_last <= 1'b0;
      o_valid  <= 1'b0;
      o_done   <= 1'b0;
    end else begin
      ret_vld  <= iss_vld && i_en;
      ret_cmd  <= iss_cmd;
      ret_last <= iss_last;
      o_valid  <= ret_vld && i_en;           // flush in-flight words on abort
      o_done   <= ret_vld && ret_last && i_en;
    end
  end

  always_ff @(posedge i_sys_clk) begin
    if (ret_vld) begin
      o_payload.preamble <= ret_cmd ? `HDR_PRE_CMD : `HDR_PRE_DATA;
      o_payload.data     <= ret_cmd ? {i_ccc_code, 8'h00} : i_rd_data;
    end
  end

endmodule

/* src/ddr_frame_gen.sv */
// ddr frame generator
`timescale 1ns/10ps
`include "hdr_cfg.svh"

module ddr_frame_gen (
  input  logic                    i_sys_clk,
  input  logic                    i_sys_rst_n,
  input  logic                    i_en,
  input  logic [`HDR_CNT_W-1:0]   i_word_cnt,
  input  logic [`HDR_DATA_W-1:0]  i_rd_data,
  output logic                    o_rd_en,
  output logic [`HDR_ADDR_W-1:0]  o_rd_addr,
  output logic                    o_valid,
  output hdr_pkg::hdr_payload_t   o_payload,
  output logic                    o_done
);

  logic                   en_d;
  logic                   busy;
  logic [`HDR_CNT_W-1:0]  left;
  logic [`HDR_ADDR_W-1:0] ptr;
  logic                   ret_vld;
  logic                   ret_last;
  logic                   rd_last;  // tags the read in flight

  always_ff @(posedge i_sys_clk or negedge i_sys_rst_n) begin
    if (!i_sys_rst_n) begin
      en_d      <= 1'b0;
      busy      <= 1'b0;
      left      <= '0;
      ptr       <= `HDR_DDR_BASE;
      rd_last   <= 1'b0;
      o_rd_en   <= 1'b0;
      o_rd_addr <= `HDR_IDLE_ADDR;
    end else begin
      en_d      <= i_en;
      rd_last   <= 1'b0;
      o_rd_en   <= 1'b0;
      o_rd_addr <= `HDR_IDLE_ADDR;
      if (!i_en) begin
        busy <= 1'b0;
      end else if (!en_d) begin              // rising edge loads the counter
        busy <= (i_word_cnt != '0);
        left <= i_word_cnt;
        ptr  <= `HDR_DDR_BASE;
        if (i_word_cnt != '0) begin
          o_rd_en   <= 1'b1;
          o_rd_addr <= `HDR_DDR_BASE;
          rd_last   <= (i_word_cnt == 1);
          ptr       <= `HDR_DDR_BASE + 1'b1;
          left      <= i_word_cnt - 1'b1;
          busy      <= (i_word_cnt != 1);
        end
      end else if (busy) begin
        o_rd_en   <= 1'b1;
        o_rd_addr <= ptr;
        rd_last   <= (left == 1);
        ptr       <= ptr + 1'b1;
        left      <= left - 1'b1;
        busy      <= (left != 1);
      end
    end
  end

  always_ff @(posedge i_sys_clk or negedge i_sys_rst_n) begin
    if (!i_sys_rst_n) begin
      ret_vld  <= 1'b0;
      ret_last <= 1'b0;
      o_valid  <= 1'b0;
      o_done   <= 1'b0;
    end else begin
      ret_vld  <= o_rd_en && i_en;
      ret_last <= rd_last;
      o_valid  <= ret_vld && i_en;
      o_done   <= ret_vld && ret_last && i_en;  // with the last word
    end
  end

  always_ff @(posedge i_sys_clk) begin
    if (ret_vld) begin
      o_payload.preamble <= `HDR_PRE_DATA;
      o_payload.data     <= i_rd_data;
    end
  end

endmodule

/* src/hdr_cfg.svh */
// hdr-ddr path configuration
`ifndef HDR_CFG_SVH
`define HDR_CFG_SVH

// bus and field widths
`define HDR_ADDR_W      12
`define HDR_DATA_W      16
`define HDR_CNT_W       4        // word count from 1 to 15
`define HDR_MODE_W      3
`define HDR_CODE_W      8

`define HDR_MEM_DEPTH   1024     // register file entries

// mode codes
`define HDR_MODE_DDR    3'd6

// register file map
`define HDR_DUMMY_ADDR  12'd450  // payload of the dummy ccc frame
`define HDR_IDLE_ADDR   12'd1000 // parked address while the strobe is low
`define HDR_CCC_BASE    12'd0
`define HDR_DDR_BASE    12'd64

// word preambles
`define HDR_PRE_CMD     2'b01
`define HDR_PRE_DATA    2'b10

`endif

/* src/hdr_engine.sv */
// hdr sequencer
`timescale 1ns/10ps
`include "hdr_cfg.svh"

module hdr_engine (
  input  logic                    i_sys_clk,
  input  logic                    i_sys_rst_n,
  input  logic                    i_hdr_en,
  input  logic                    i_cp,
  input  logic                    i_toc,
  input  logic [`HDR_MODE_W-1:0]  i_mode,
  input  logic [`HDR_CNT_W-1:0]   i_word_cnt,
  input  logic [`HDR_CODE_W-1:0]  i_ccc_code,
  input  logic                    i_ccc_done,
  input  logic                    i_ddr_done,
  output logic                    o_ccc_en,
  output logic                    o_ddr_en,
  output logic                    o_dummy,
  output logic [`HDR_CNT_W-1:0]   o_word_cnt,
  output logic [`HDR_CODE_W-1:0]  o_ccc_code,
  output hdr_pkg::hdr_path_e      o_path_sel,
  output logic                    o_hdr_done
);

  import hdr_pkg::*;

  hdr_state_e             state;
  logic                   toc_q;
  logic [`HDR_MODE_W-1:0] mode_q;
  logic                   launch;     // enable goes high next cycle
  logic                   frame_done;
  logic                   exit_now;
  logic                   restart;
  logic                   sample_cfg;

  assign frame_done = ((state == ST_CCC) && i_ccc_done) || ((state == ST_DDR) && i_ddr_done);
  assign exit_now   = toc_q || (mode_q != `HDR_MODE_DDR);
  assign restart    = i_hdr_en && frame_done && !o_dummy && !exit_now;
  assign sample_cfg = ((state == ST_IDLE) && i_hdr_en) || restart;

  // configuration sampled at start and at every restart
  always_ff @(posedge i_sys_clk or negedge i_sys_rst_n) begin
    if (!i_sys_rst_n) begin
      toc_q      <= 1'b0;
      mode_q     <= `HDR_MODE_DDR;
      o_word_cnt <= '0;
      o_ccc_code <= '0;
    end else if (sample_cfg) begin
      toc_q      <= i_toc;
      mode_q     <= i_mode;
      o_word_cnt <= i_word_cnt;
      o_ccc_code <= i_ccc_code;
    end
  end

  always_ff @(posedge i_sys_clk or negedge i_sys_rst_n) begin
    if (!i_sys_rst_n) begin
      state      <= ST_IDLE;
      launch     <= 1'b0;
      o_ccc_en   <= 1'b0;
      o_ddr_en   <= 1'b0;
      o_dummy    <= 1'b0;
      o_path_sel <= PATH_DDR;
      o_hdr_done <= 1'b0;
    end else begin
      o_hdr_done <= 1'b0;
      launch     <= 1'b0;
      if (state == ST_IDLE) begin
        if (i_hdr_en) begin              // first frame starts right away
          state      <= i_cp ? ST_CCC : ST_DDR;
          o_ccc_en   <= i_cp;
          o_ddr_en   <= !i_cp;
          o_path_sel <= i_cp ? PATH_CCC : PATH_DDR;
        end
      end else if (!i_hdr_en) begin      // abort without a done pulse
        state    <= ST_IDLE;
        o_ccc_en <= 1'b0;
        o_ddr_en <= 1'b0;
        o_dummy  <= 1'b0;
      end else if (frame_done) begin
        o_ccc_en <= 1'b0;                // low for a cycle so the next frame sees an edge
        o_ddr_en <= 1'b0;
        if (o_dummy) begin
          o_dummy    <= 1'b0;
          state      <= ST_DDR;
          o_path_sel <= PATH_DDR;
          launch     <= 1'b1;
        end else if (exit_now) begin
          o_hdr_done <= 1'b1;
          state      <= ST_IDLE;
        end else begin
          launch <= 1'b1;
          if (i_cp) begin
            state      <= ST_CCC;
            o_path_sel <= PATH_CCC;
          end else if (state == ST_CCC) begin
            o_dummy <= 1'b1;             // ccc to ddr goes through the dummy frame first
          end else begin
            state      <= ST_DDR;
            o_path_sel <= PATH_DDR;
          end
        end
      end else if (launch) begin
        o_ccc_en <= (state == ST_CCC);
        o_ddr_en <= (state == ST_DDR);
      end
    end
  end

  a_one_path: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst_n)
    !(o_ccc_en && o_ddr_en));

  a_done_pulse: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst_n)
    o_hdr_done |=> !o_hdr_done);

endmodule

/* src/hdr_parity_stage.sv */
// hdr-ddr parity stage
`timescale 1ns/10ps
`include "hdr_cfg.svh"

module hdr_parity_stage (
  input  logic                   i_sys_clk,
  input  logic                   i_sys_rst_n,
  input  hdr_pkg::hdr_path_e     i_path_sel,
  input  logic                   i_ccc_valid,
  input  hdr_pkg::hdr_payload_t  i_ccc_payload,
  input  logic                   i_ddr_valid,
  input  hdr_pkg::hdr_payload_t  i_ddr_payload,
  output logic                   o_word_valid,
  output hdr_pkg::hdr_word_t     o_word
);

  import hdr_pkg::*;

  // ones on the odd bit positions
  localparam logic [`HDR_DATA_W-1:0] ODD_MASK = {(`HDR_DATA_W/2){2'b10}};

  hdr_payload_t sel_payload;
  logic         sel_valid;
  logic         p1;
  logic         p0;

  assign sel_valid   = (i_path_sel == PATH_CCC) ? i_ccc_valid : i_ddr_valid;
  assign sel_payload = (i_path_sel == PATH_CCC) ? i_ccc_payload : i_ddr_payload;

  assign p1 = ^(sel_payload.data & ODD_MASK);
  assign p0 = ~^(sel_payload.data & ~ODD_MASK);  // inverted even parity

  always_ff @(posedge i_sys_clk or negedge i_sys_rst_n) begin
    if (!i_sys_rst_n) o_word_valid <= 1'b0;
    else              o_word_valid <= sel_valid;
  end

  always_ff @(posedge i_sys_clk) begin
    if (sel_valid) o_word <= {sel_payload, p1, p0};
  end

  // the engine switches paths only between frames
  a_path_match: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst_n)
    !((i_path_sel == PATH_CCC) && i_ddr_valid) && !((i_path_sel == PATH_DDR) && i_ccc_valid));

endmodule

/* src/hdr_pkg.sv */
// hdr-ddr shared types
`include "hdr_cfg.svh"

package hdr_pkg;

  // sequencer state
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_CCC,
    ST_DDR
  } hdr_state_e;

  // generator feeding the output
  typedef enum logic {
    PATH_DDR,
    PATH_CCC
  } hdr_path_e;

  // preamble and payload before parity
  typedef struct packed {
    logic [1:0]             preamble;
    logic [`HDR_DATA_W-1:0] data;
  } hdr_payload_t;

  // full 20-bit word as it leaves the path
  typedef struct packed {
    logic [1:0]             preamble;
    logic [`HDR_DATA_W-1:0] data;
    logic [1:0]             parity;  // {p1, p0}
  } hdr_word_t;

endpackage

/* src/hdr_regf.sv */
// hdr register file
`timescale 1ns/10ps
`include "hdr_cfg.svh"

module hdr_regf (
  input  logic                    i_sys_clk,
  input  logic                    i_sys_rst_n,
  input  logic                    i_wr_en,
  input  logic [`HDR_ADDR_W-1:0]  i_wr_addr,
  input  logic [`HDR_DATA_W-1:0]  i_wr_data,
  input  logic                    i_rd_en_a,
  input  logic [`HDR_ADDR_W-1:0]  i_rd_addr_a,
  input  logic                    i_rd_en_b,
  input  logic [`HDR_ADDR_W-1:0]  i_rd_addr_b,
  output logic [`HDR_DATA_W-1:0]  o_rd_data_a,
  output logic [`HDR_DATA_W-1:0]  o_rd_data_b
);

  localparam int IDX_W = $clog2(`HDR_MEM_DEPTH);

  logic [`HDR_DATA_W-1:0] mem [`HDR_MEM_DEPTH];

  always_ff @(posedge i_sys_clk) begin
    if (i_wr_en) mem[i_wr_addr[IDX_W-1:0]] <= i_wr_data;   // host side
    if (i_rd_en_a) o_rd_data_a <= mem[i_rd_addr_a[IDX_W-1:0]];  // ccc generator
    if (i_rd_en_b) o_rd_data_b <= mem[i_rd_addr_b[IDX_W-1:0]];  // ddr generator
  end

  // generators must stay inside the array
  a_rd_range_a: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst_n)
    i_rd_en_a |-> (i_rd_addr_a < `HDR_MEM_DEPTH));

  a_rd_range_b: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst_n)
    i_rd_en_b |-> (i_rd_addr_b < `HDR_MEM_DEPTH));

endmodule

/* src/hdr_top.sv */
// hdr-ddr transfer path
`timescale 1ns/10ps
`include "hdr_cfg.svh"

module hdr_top (
  input  logic                    i_sys_clk,
  input  logic                    i_sys_rst_n,
  input  logic                    i_hdr_en,
  input  logic                    i_cp,
  input  logic                    i_toc,
  input  logic [`HDR_MODE_W-1:0]  i_mode,
  input  logic [`HDR_CNT_W-1:0]   i_word_cnt,
  input  logic [`HDR_CODE_W-1:0]  i_ccc_code,
  input  logic                    i_regf_wr_en,
  input  logic [`HDR_ADDR_W-1:0]  i_regf_wr_addr,
  input  logic [`HDR_DATA_W-1:0]  i_regf_wr_data,
  output logic                    o_word_valid,
  output hdr_pkg::hdr_word_t      o_word,
  output logic                    o_hdr_done
);

  import hdr_pkg::*;

  logic                   ccc_en, ddr_en, dummy;
  logic                   ccc_done, ddr_done;
  logic [`HDR_CNT_W-1:0]  word_cnt;
  logic [`HDR_CODE_W-1:0] ccc_code;
  hdr_path_e              path_sel;
  logic                   ccc_rd_en, ddr_rd_en;
  logic [`HDR_ADDR_W-1:0] ccc_rd_addr, ddr_rd_addr;
  logic [`HDR_DATA_W-1:0] ccc_rd_data, ddr_rd_data;
  logic                   ccc_valid, ddr_valid;
  hdr_payload_t           ccc_payload, ddr_payload;

  hdr_engine u_engine (
    .i_sys_clk, .i_sys_rst_n, .i_hdr_en, .i_cp, .i_toc, .i_mode, .i_word_cnt, .i_ccc_code,
    .i_ccc_done (ccc_done),   .i_ddr_done (ddr_done),
    .o_ccc_en   (ccc_en),     .o_ddr_en   (ddr_en),     .o_dummy    (dummy),
    .o_word_cnt (word_cnt),   .o_ccc_code (ccc_code),   .o_path_sel (path_sel),
    .o_hdr_done
  );

  hdr_regf u_regf (
    .i_sys_clk, .i_sys_rst_n,
    .i_wr_en     (i_regf_wr_en), .i_wr_addr (i_regf_wr_addr), .i_wr_data (i_regf_wr_data),
    .i_rd_en_a   (ccc_rd_en),    .i_rd_addr_a (ccc_rd_addr),  // port a serves ccc
    .i_rd_en_b   (ddr_rd_en),    .i_rd_addr_b (ddr_rd_addr),
    .o_rd_data_a (ccc_rd_data),  .o_rd_data_b (ddr_rd_data)
  );

  ccc_frame_gen u_ccc_gen (
    .i_sys_clk, .i_sys_rst_n,
    .i_en      (ccc_en),      .i_dummy   (dummy),       .i_word_cnt (word_cnt),
    .i_ccc_code (ccc_code),   .i_rd_data (ccc_rd_data),
    .o_rd_en   (ccc_rd_en),   .o_rd_addr (ccc_rd_addr), .o_valid (ccc_valid),
    .o_payload (ccc_payload), .o_done    (ccc_done)
  );

  ddr_frame_gen u_ddr_gen (
    .i_sys_clk, .i_sys_rst_n,
    .i_en      (ddr_en),      .i_word_cnt (word_cnt),   .i_rd_data (ddr_rd_data),
    .o_rd_en   (ddr_rd_en),   .o_rd_addr (ddr_rd_addr), .o_valid (ddr_valid),
    .o_payload (ddr_payload), .o_done    (ddr_done)
  );

  hdr_parity_stage u_parity (
    .i_sys_clk, .i_sys_rst_n,
    .i_path_sel  (path_sel),
    .i_ccc_valid (ccc_valid), .i_ccc_payload (ccc_payload),
    .i_ddr_valid (ddr_valid), .i_ddr_payload (ddr_payload),
    .o_word_valid, .o_word
  );

endmodule

/* tb.f */
+incdir+src
src/hdr_pkg.sv
src/hdr_engine.sv
src/hdr_regf.sv
src/ccc_frame_gen.sv
src/ddr_frame_gen.sv
src/hdr_parity_stage.sv
src/hdr_top.sv
bench/tb_clk_gen.sv
bench/tb_hdr.sv
